//--- include/lsq_defines.svh
/*
 * load/store buffer configuration: queue depth, tag and opcode widths,
 * common data bus port count and control register offsets
 */
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// buffer geometry
`define LSQ_DEPTH_BITS 3
`define LSQ_DEPTH      (1 << `LSQ_DEPTH_BITS)

// reorder buffer tag, zero means value present
`define ROB_TAG_W      5

`define CDB_PORTS      2
`define OPCODE_W       12

// AXI4-Lite register byte offsets
`define CSR_CTRL       4'h0
`define CSR_STATUS     4'h4
`define CSR_ISSUED     4'h8

`endif

//--- hw/lsq_pkg.sv
/*
 * load/store buffer types: dispatch, stored entry, CDB broadcast, issue
 */
`include "lsq_defines.svh"

package lsq_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [4:0]            reg_idx_t;

    // one memory instruction from dispatch
    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic                 is_store;
        reg_idx_t             rd;
        rob_tag_t             rob_tag;
        rob_tag_t             base_tag;
        logic [31:0]          base_val;
        rob_tag_t             data_tag;
        logic [31:0]          data_val;
        logic [31:0]          imm;
    } lsq_dispatch_t;

    // buffered entry, addr valid once base_tag is zero
    typedef struct packed {
        lsq_dispatch_t ins;
        logic [31:0]   addr;
    } lsq_entry_t;

    typedef struct packed {
        rob_tag_t    tag;
        logic [31:0] value;
    } cdb_t;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic                 is_store;
        reg_idx_t             rd;
        rob_tag_t             rob_tag;
        logic [31:0]          addr;
        logic [31:0]          data;
    } lsq_issue_t;

endpackage

//--- hw/ls_buffer.sv
/*
 * load/store buffer: program-ordered circular queue with CDB wakeup,
 * effective address generation and in-order issue gated by store commit
 */
`include "lsq_defines.svh"

module ls_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc_valid,
    input  lsq_pkg::lsq_dispatch_t   alloc,
    output logic                     alloc_ready,
    input  lsq_pkg::cdb_t            cdb [`CDB_PORTS],
    input  logic [`ROB_TAG_W-1:0]    rob_head,
    input  logic                     flush,
    input  logic                     issue_en,
    output logic                     issue_valid,
    output lsq_pkg::lsq_issue_t      issue,
    input  logic                     issue_ready,
    output logic [`LSQ_DEPTH_BITS:0] occupancy,
    output logic                     issue_fire
);
    import lsq_pkg::*;

    lsq_entry_t                 mem [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0]      busy;
    logic [`LSQ_DEPTH_BITS-1:0] head;
    logic [`LSQ_DEPTH_BITS-1:0] tail;
    logic [`LSQ_DEPTH_BITS:0]   count;
    lsq_entry_t                 head_entry;
    lsq_entry_t                 alloc_entry;
    logic                       push;
    logic                       pop;
    logic                       head_ready;

    // compare both operand tags against the bus, lowest port wins
    function automatic lsq_entry_t wake(input lsq_entry_t e);
        lsq_entry_t r;
        logic       base_hit;
        logic       data_hit;
        r = e;
        base_hit = 1'b0;
        data_hit = 1'b0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (!base_hit && cdb[p].tag != '0 && cdb[p].tag == e.ins.base_tag) begin
                base_hit = 1'b1;
                r.ins.base_tag = '0;
                r.ins.base_val = cdb[p].value;
                r.addr = cdb[p].value + e.ins.imm;
            end
            if (!data_hit && cdb[p].tag != '0 && cdb[p].tag == e.ins.data_tag) begin
                data_hit = 1'b1;
                r.ins.data_tag = '0;
                r.ins.data_val = cdb[p].value;
            end
        end
        return r;
    endfunction

    assign head_entry  = mem[head];
    assign alloc_ready = (count != `LSQ_DEPTH);
    assign push        = alloc_valid && alloc_ready;
    assign issue_fire  = issue_valid && issue_ready;
    assign occupancy   = count;

    // stores wait for the ROB head so they only reach memory at commit
    assign head_ready = busy[head] && issue_en
                        && head_entry.ins.base_tag == '0
                        && head_entry.ins.data_tag == '0
                        && (!head_entry.ins.is_store || head_entry.ins.rob_tag == rob_head);

    // output register refills when empty or taken this cycle
    assign pop = head_ready && (!issue_valid || issue_ready);

    always_comb begin
        alloc_entry.ins  = alloc;
        alloc_entry.addr = alloc.base_val + alloc.imm;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy        <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (push) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (pop) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop) begin
                issue_valid <= 1'b1;
            end else if (issue_fire) begin
                issue_valid <= 1'b0;
            end
        end
    end

    // entry payload and issue payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (push && tail == `LSQ_DEPTH_BITS'(i)) begin
                mem[i] <= wake(alloc_entry);
            end else if (busy[i]) begin
                mem[i] <= wake(mem[i]);
            end
        end
        if (pop) begin
            issue.opcode   <= head_entry.ins.opcode;
            issue.is_store <= head_entry.ins.is_store;
            issue.rd       <= head_entry.ins.rd;
            issue.rob_tag  <= head_entry.ins.rob_tag;
            issue.addr     <= head_entry.addr;
            issue.data     <= head_entry.ins.data_val;
        end
    end

    // count and busy bits must agree, the tail slot is free on every push
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !busy[tail]);

    a_issue_stable: assert property (@(posedge clk) disable iff (rst)
        issue_valid && !issue_ready && !flush |=> issue_valid && $stable(issue));

endmodule

//--- hw/lsq_csr.sv
/*
 * AXI4-Lite register block for the load/store buffer: issue enable,
 * software flush, occupancy readback and an issued instruction counter
 */
`include "lsq_defines.svh"

module lsq_csr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [3:0]                 awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [3:0]                 araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       issue_en,
    output logic                       sw_flush,
    input  logic [`LSQ_DEPTH_BITS:0]   occupancy,
    input  logic                       issue_fire
);

    logic        wr_hs;
    logic        rd_hs;
    logic [31:0] issued;

    // AW and W accepted together, one outstanding response
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign arready = !rvalid;
    assign rd_hs   = arvalid && arready;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            issue_en <= 1'b1;
            sw_flush <= 1'b0;
            issued   <= '0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // flush bit is write-one, self-clearing
            sw_flush <= wr_hs && awaddr == `CSR_CTRL && wstrb[0] && wdata[1];
            if (wr_hs && awaddr == `CSR_CTRL && wstrb[0]) begin
                issue_en <= wdata[0];
            end
            if (wr_hs && awaddr == `CSR_ISSUED && |wstrb) begin
                issued <= '0;
            end else if (issue_fire) begin
                issued <= issued + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            case (araddr)
                `CSR_CTRL:   rdata <= {31'b0, issue_en};
                `CSR_STATUS: rdata <= 32'(occupancy);
                `CSR_ISSUED: rdata <= issued;
                default:     rdata <= '0;
            endcase
        end
    end

    a_bvalid_after_hs: assert property (@(posedge clk) disable iff (rst)
        $rose(bvalid) |-> $past(wr_hs));

endmodule

//--- hw/lsq_top.sv
/*
 * load/store queue top: buffer plus its AXI4-Lite control registers
 */
`include "lsq_defines.svh"

module lsq_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_valid,
    input  lsq_pkg::lsq_dispatch_t alloc,
    output logic                   alloc_ready,
    input  lsq_pkg::cdb_t          cdb [`CDB_PORTS],
    input  logic [`ROB_TAG_W-1:0]  rob_head,
    input  logic                   flush,
    output logic                   issue_valid,
    output lsq_pkg::lsq_issue_t    issue,
    input  logic                   issue_ready,
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    logic                     issue_en;
    logic                     sw_flush;
    logic [`LSQ_DEPTH_BITS:0] occupancy;
    logic                     issue_fire;

    // core flush and software flush both empty the buffer
    ls_buffer u_buffer (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc       (alloc),
        .alloc_ready (alloc_ready),
        .cdb         (cdb),
        .rob_head    (rob_head),
        .flush       (flush | sw_flush),
        .issue_en    (issue_en),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .occupancy   (occupancy),
        .issue_fire  (issue_fire)
    );

    lsq_csr u_csr (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .issue_en   (issue_en),
        .sw_flush   (sw_flush),
        .occupancy  (occupancy),
        .issue_fire (issue_fire)
    );

endmodule

//--- sim/tb_lsq.sv
/*
 * testbench for the load/store queue: directed tests of dispatch, CDB wakeup,
 * store commit gating, back-pressure and the AXI4-Lite registers
 */
`include "lsq_defines.svh"

module tb_lsq;
    import lsq_pkg::*;

    // about four times the combined length of six tests of up to 80 cycles
    localparam int MAX_CYCLES = 2000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  alloc_valid;
    lsq_dispatch_t         alloc;
    logic                  alloc_ready;
    cdb_t                  cdb [`CDB_PORTS];
    logic [`ROB_TAG_W-1:0] rob_head;
    logic                  flush;
    logic                  issue_valid;
    lsq_issue_t            issue;
    logic                  issue_ready;
    logic [3:0]            awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [3:0]            araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int cycles = 0;

    lsq_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_at_start);
        tests++;
        if (errors == errors_at_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - errors_at_start);
        end
    endtask

    // random ready load with both operand tags zero
    function automatic lsq_dispatch_t make_load(input logic [`ROB_TAG_W-1:0] rob);
        lsq_dispatch_t d;
        d          = '0;
        d.opcode   = 12'($urandom);
        d.rd       = 5'($urandom);
        d.rob_tag  = rob;
        d.base_val = $urandom;
        d.imm      = $urandom_range(0, 4095);
        return d;
    endfunction

    // expected issue record with the address as base plus immediate
    function automatic lsq_issue_t issued_form(input lsq_dispatch_t d, input logic [31:0] base,
                                               input logic [31:0] data);
        lsq_issue_t r;
        r.opcode   = d.opcode;
        r.is_store = d.is_store;
        r.rd       = d.rd;
        r.rob_tag  = d.rob_tag;
        r.addr     = base + d.imm;
        r.data     = data;
        return r;
    endfunction

    task automatic dispatch(input lsq_dispatch_t d);
        alloc_valid = 1'b1;
        alloc       = d;
        while (!alloc_ready) @(negedge clk);
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    task automatic broadcast(input int port, input logic [`ROB_TAG_W-1:0] tag,
                             input logic [31:0] value);
        cdb[port].tag   = tag;
        cdb[port].value = value;
        @(negedge clk);
        cdb[port] = '0;
    endtask

    task automatic expect_issue(input lsq_issue_t exp);
        issue_ready = 1'b1;
        while (!issue_valid) @(negedge clk);
        check("issue.opcode", 32'(issue.opcode), 32'(exp.opcode));
        check("issue.is_store", 32'(issue.is_store), 32'(exp.is_store));
        check("issue.rd", 32'(issue.rd), 32'(exp.rd));
        check("issue.rob_tag", 32'(issue.rob_tag), 32'(exp.rob_tag));
        check("issue.addr", issue.addr, exp.addr);
        check("issue.data", issue.data, exp.data);
        // transfer completes at the next rising edge
        @(negedge clk);
    endtask

    task automatic expect_no_issue(input int n);
        repeat (n) begin
            @(negedge clk);
            check("issue_valid", 32'(issue_valid), 0);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // ready follows valid within the cycle
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        check("wready", 32'(wready), 1);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check("bvalid", 32'(bvalid), 1);
        check("bresp", 32'(bresp), 0);
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        check("rvalid", 32'(rvalid), 1);
        check("rresp", 32'(rresp), 0);
        data    = rdata;
    endtask

    task automatic test_reset();
        int          errors_at_start = errors;
        logic [31:0] v;
        check("alloc_ready", 32'(alloc_ready), 1);
        check("issue_valid", 32'(issue_valid), 0);
        axi_read(`CSR_STATUS, v);
        check("STATUS", v, 0);
        axi_read(`CSR_ISSUED, v);
        check("ISSUED", v, 0);
        axi_read(`CSR_CTRL, v);
        check("CTRL", v, 1);
        report_test("reset values", errors_at_start);
    endtask

    task automatic test_ready_loads();
        int            errors_at_start = errors;
        lsq_dispatch_t d [3];
        // hold the output until all three loads are buffered
        issue_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            d[i] = make_load(5'(i + 1));
            dispatch(d[i]);
        end
        for (int i = 0; i < 3; i++) begin
            expect_issue(issued_form(d[i], d[i].base_val, d[i].data_val));
        end
        report_test("ready loads in order", errors_at_start);
    endtask

    task automatic test_wakeup();
        int            errors_at_start = errors;
        lsq_dispatch_t ld;
        lsq_dispatch_t st;
        ld          = make_load(5'd4);
        ld.base_tag = 5'd9;
        dispatch(ld);
        expect_no_issue(5);
        broadcast(1, 5'd9, 32'h1000_0040);
        expect_issue(issued_form(ld, 32'h1000_0040, ld.data_val));
        // store waits on both base and data
        st          = make_load(5'd6);
        st.is_store = 1'b1;
        st.base_tag = 5'd10;
        st.data_tag = 5'd11;
        rob_head    = 5'd6;
        dispatch(st);
        broadcast(0, 5'd11, 32'hcafe_f00d);
        expect_no_issue(2);
        broadcast(0, 5'd10, 32'h2000_0100);
        expect_issue(issued_form(st, 32'h2000_0100, 32'hcafe_f00d));
        report_test("CDB wakeup", errors_at_start);
    endtask

    task automatic test_store_order();
        int            errors_at_start = errors;
        lsq_dispatch_t st;
        lsq_dispatch_t ld;
        st          = make_load(5'd7);
        st.is_store = 1'b1;
        st.data_val = $urandom;
        ld          = make_load(5'd8);
        rob_head    = 5'd1;
        dispatch(st);
        dispatch(ld);
        expect_no_issue(6);
        rob_head = 5'd7;
        expect_issue(issued_form(st, st.base_val, st.data_val));
        expect_issue(issued_form(ld, ld.base_val, ld.data_val));
        report_test("store commit gating", errors_at_start);
    endtask

    task automatic test_backpressure();
        int            errors_at_start = errors;
        lsq_dispatch_t sent [$];
        lsq_dispatch_t d;
        logic [31:0]   v;
        axi_write(`CSR_ISSUED, 32'h0);
        issue_ready = 1'b0;
        while (alloc_ready && sent.size() < `LSQ_DEPTH + 4) begin
            d = make_load(5'(sent.size() + 1));
            dispatch(d);
            sent.push_back(d);
        end
        check("accepted dispatches", sent.size(), `LSQ_DEPTH + 1);
        foreach (sent[i]) begin
            expect_issue(issued_form(sent[i], sent[i].base_val, sent[i].data_val));
        end
        axi_read(`CSR_ISSUED, v);
        check("ISSUED", v, `LSQ_DEPTH + 1);
        axi_read(`CSR_STATUS, v);
        check("STATUS", v, 0);
        report_test("back-pressure and drain", errors_at_start);
    endtask

    task automatic test_ctrl();
        int          errors_at_start = errors;
        logic [31:0] v;
        axi_write(`CSR_CTRL, 32'h0);
        issue_ready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            dispatch(make_load(5'(20 + i)));
        end
        expect_no_issue(4);
        axi_read(`CSR_STATUS, v);
        check("STATUS", v, 3);
        // flush with issue still off
        axi_write(`CSR_CTRL, 32'h2);
        // sw_flush reaches the buffer one edge after the write
        @(negedge clk);
        axi_read(`CSR_STATUS, v);
        check("STATUS", v, 0);
        axi_write(`CSR_CTRL, 32'h1);
        expect_no_issue(6);
        axi_read(`CSR_ISSUED, v);
        check("ISSUED", v, `LSQ_DEPTH + 1);
        axi_write(`CSR_ISSUED, 32'h0);
        axi_read(`CSR_ISSUED, v);
        check("ISSUED", v, 0);
        report_test("control and flush", errors_at_start);
    endtask

    initial begin
        void'($urandom(32'h4539));
        rst         = 1'b1;
        alloc_valid = 1'b0;
        alloc       = '0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb[p] = '0;
        end
        rob_head    = '0;
        flush       = 1'b0;
        issue_ready = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_ready_loads();
        test_wakeup();
        test_store_order();
        test_backpressure();
        test_ctrl();
        $display("tests %0d, checks %0d, mismatches %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
hw/lsq_pkg.sv
hw/ls_buffer.sv
hw/lsq_csr.sv
hw/lsq_top.sv
sim/tb_lsq.sv

//--- Makefile
# Verilator build and run of the load/store queue testbench

SIM      ?= verilator
TOP      := tb_lsq
FILELIST := sim.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
